// ==== verification/fpAdderVectors.txt ====
// opA opB subtract expectedResult expectedFlags, all hex
// flags are {invalid, overflow, inexact}
3F800000 3F800000 0 40000000 0
3F800000 40000000 0 40400000 0
40400000 3F800000 1 40000000 0
3F800000 40400000 1 C0000000 0
BF800000 C0000000 0 C0400000 0
3FC00000 3F000000 0 40000000 0
3F800000 30000000 0 3F800000 1
3F800000 33800000 0 3F800000 1
3F800001 33800000 0 3F800002 1
3F800000 33C00000 0 3F800001 1
3FFFFFFF 33800000 0 40000000 1
3F800000 30000000 1 3F800000 1
3F800000 33800001 1 3F7FFFFF 1
3FC00000 3FA00000 1 3E800000 0
3F800001 3F800000 1 34000000 0
00800001 00800000 1 00000001 0
01000000 00C00000 1 00400000 0
00000001 00800000 0 00800001 0
00400000 00400000 0 00800000 0
00000003 00000005 0 00000008 0
7FC00000 3F800000 0 7FC00000 4
3F800000 7F800001 0 7FC00000 4
7F800000 7F800000 1 7FC00000 4
7F800000 FF800000 0 7FC00000 4
7F800000 7F800000 0 7F800000 0
3F800000 7F800000 1 FF800000 0
80000000 80000000 0 80000000 0
00000000 00000000 1 00000000 0
80000000 00000000 1 80000000 0
00000000 3F800000 1 BF800000 0
40000000 80000000 0 40000000 0
3FC00000 3FC00000 1 00000000 0
BFC00000 3FC00000 0 00000000 0
3F800000 2F800000 0 3F800000 1
2B800000 40800000 1 C0800000 1
7F7FFFFF 7F7FFFFF 0 7F800000 3
FF7FFFFF 7F7FFFFF 1 FF800000 3
7F7FFFFF 73000000 0 7F800000 3

// ==== all.f ====
common/fpPkg.sv
rtl/fpClassify.sv
fpAdder/alignment.sv
fpAdder/mantissaAdder.sv
fpAdder/normalizeRound.sv
rtl/fpAdderControl.sv
rtl/fpAdderTop.sv
verification/fpAdderAssert.sv
verification/fpAdderTb.sv

// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS = --binary --timing --assert -Wno-fatal
TOP = fpAdderTb
FILELIST = all.f
OBJDIR = obj_dir
SIM_BIN = $(OBJDIR)/V$(TOP)
LOG = sim.log
VECTORS = verification/fpAdderVectors.txt
SOURCES = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

run: $(SIM_BIN) $(VECTORS)
	./$(SIM_BIN) > $(LOG) 2>&1 || true
	@cat $(LOG)
	@if grep -q "SOME TESTS FAILED" $(LOG); then echo "simulation failed"; exit 1; fi
	@grep -q "ALL TESTS PASSED" $(LOG) || (echo "simulation did not complete"; exit 1)

clean:
	rm -rf $(OBJDIR) $(LOG)

// ==== verification/fpAdderTb.sv ====
// Float adder testbench
`timescale 1ns/1ps
`default_nettype none

module fpAdderTb;

    localparam int clockPeriod = 100;
    localparam int resultTimeout = 20;
    localparam int groupSize = 5;
    localparam string vectorFile = "verification/fpAdderVectors.txt";

    logic clk;
    logic reset;
    logic inValid;
    fpPkg::fpWord opA;
    fpPkg::fpWord opB;
    logic subtract;
    fpPkg::fpWord result;
    fpPkg::fpFlags flags;
    logic outValid;

    fpPkg::fpWord vecA[$];
    fpPkg::fpWord vecB[$];
    logic vecSub[$];
    fpPkg::fpWord vecResult[$];
    fpPkg::fpFlags vecFlags[$];
    fpPkg::fpWord expectedResult[$];
    fpPkg::fpFlags expectedFlags[$];
    int startCycle[$];
    int cycleCount = 0;

    fpAdderTop i_dut
    (
        .clk(clk),
        .reset(reset),
        .inValid(inValid),
        .opA(opA),
        .opB(opB),
        .subtract(subtract),
        .result(result),
        .flags(flags),
        .outValid(outValid)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #(clockPeriod / 2) clk = ~clk;
    end

    always @(posedge clk)
        cycleCount <= cycleCount + 1;

    task automatic stopOnFailure();
        $display("SOME TESTS FAILED");
        $fatal(1, "simulation stopped at the first failure");
    endtask

    task automatic readVectors();
        int fd;
        int count;
        string line;
        logic [31:0] a, b, s, r, f;
        fd = $fopen(vectorFile, "r");
        if (fd == 0)
        begin
            $display("ERROR: cannot open the vector file %s", vectorFile);
            stopOnFailure();
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            count = $sscanf(line, "%h %h %h %h %h", a, b, s, r, f); // comment lines give 0.
            if (count == 5)
            begin
                vecA.push_back(a);
                vecB.push_back(b);
                vecSub.push_back(s[0]);
                vecResult.push_back(r);
                vecFlags.push_back(fpPkg::fpFlags'(f[2:0]));
            end
        end
        $fclose(fd);
        if (vecA.size() == 0)
        begin
            $display("ERROR: the vector file holds no vectors");
            stopOnFailure();
        end
    endtask

    task automatic checkResult(input fpPkg::fpWord actual, input fpPkg::fpWord expected,
                               input int index);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: vector %0d result %h, expected %h",
                     $time, index, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic checkFlags(input fpPkg::fpFlags actual, input fpPkg::fpFlags expected,
                              input int index);
        if (actual !== expected)
        begin
            $display("MISMATCH at %0t: vector %0d flags %b, expected %b",
                     $time, index, actual, expected);
            stopOnFailure();
        end
    endtask

    task automatic driveVectors();
        int idleCycles;
        for (int i = 0; i < vecA.size(); i++)
        begin
            @(posedge clk);
            inValid <= 1'b1;
            opA <= vecA[i];
            opB <= vecB[i];
            subtract <= vecSub[i];
            expectedResult.push_back(vecResult[i]);
            expectedFlags.push_back(vecFlags[i]);
            startCycle.push_back(cycleCount + 1); // cycle in which inValid is high.
            if ((i % groupSize) == groupSize - 1)
            begin
                idleCycles = $urandom_range(2);
                repeat (idleCycles)
                begin
                    @(posedge clk);
                    inValid <= 1'b0;
                end
            end
        end
        @(posedge clk);
        inValid <= 1'b0;
    endtask

    task automatic waitForResult();
        int waited;
        waited = 0;
        @(negedge clk);
        while (!outValid && waited < resultTimeout)
        begin
            @(negedge clk);
            waited++;
        end
        if (!outValid)
        begin
            $display("ERROR: no result arrived within %0d cycles", resultTimeout);
            stopOnFailure();
        end
    endtask

    task automatic collectResults(input int total);
        fpPkg::fpWord wantResult;
        fpPkg::fpFlags wantFlags;
        int wantCycle;
        for (int n = 0; n < total; n++)
        begin
            waitForResult();
            if (expectedResult.size() == 0)
            begin
                $display("ERROR: a result arrived with no operation outstanding");
                stopOnFailure();
            end
            wantResult = expectedResult.pop_front();
            wantFlags = expectedFlags.pop_front();
            wantCycle = startCycle.pop_front() + 3;
            if (cycleCount != wantCycle)
            begin
                $display("ERROR: result %0d came in cycle %0d instead of cycle %0d",
                         n, cycleCount, wantCycle);
                stopOnFailure();
            end
            checkResult(result, wantResult, n);
            checkFlags(flags, wantFlags, n);
        end
    endtask

    initial
    begin
        void'($urandom(32'h3706d62a));
        reset = 1'b1;
        inValid = 1'b0;
        opA = '0;
        opB = '0;
        subtract = 1'b0;
        readVectors();
        repeat (2) @(posedge clk);
        reset <= 1'b0;
        fork
            driveVectors();
            collectResults(vecA.size());
        join
        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== verification/fpAdderAssert.sv ====
// Adder pipeline assertions
`timescale 1ns/1ps
`default_nettype none

module fpAdderAssert
(
    input wire clk,
    input wire reset,
    input wire s1Valid,
    input wire outValid,
    input wire fpPkg::fpWord result,
    input wire fpPkg::fpFlags flags
);

    // two register stages between stage 1 and the output.
    validLatency: assert property (@(posedge clk) disable iff (reset)
        !$past(reset, 2) |-> (outValid == $past(s1Valid, 2)))
        else $error("outValid does not follow the stage-1 valid by two cycles");

    resetQuiet: assert property (@(posedge clk) $past(reset) |-> !outValid)
        else $error("outValid is high during reset");

    invalidNan: assert property (@(posedge clk) disable iff (reset)
        (outValid && flags.invalid) |-> (result == fpPkg::quietNan))
        else $error("invalid flag without the quiet NaN result");

endmodule

bind fpAdderControl fpAdderAssert i_assert
(
    .clk(clk),
    .reset(reset),
    .s1Valid(s1Valid),
    .outValid(outValid),
    .result(result),
    .flags(flags)
);

`default_nettype wire

// ==== rtl/fpAdderTop.sv ====
// Pipelined float adder top level
`timescale 1ns/1ps
`default_nettype none

module fpAdderTop
(
    input wire clk,
    input wire reset,
    input wire inValid,
    input wire fpPkg::fpWord opA,
    input wire fpPkg::fpWord opB,
    input wire subtract,
    output fpPkg::fpWord result,
    output fpPkg::fpFlags flags,
    output logic outValid
);

    logic signA, signB;
    fpPkg::fpExponent exponentA, exponentB;
    fpPkg::fpMantissa mantissaA, mantissaB;
    logic nanA, nanB;
    logic infA, infB;
    logic zeroA, zeroB;
    logic subA, subB;
    fpPkg::fpExponent exponentOut;
    fpPkg::alignedMantissa alignedMantissaA, alignedMantissaB;
    logic aBigger, bBigger;
    logic sticky, shiftOverflow, bypass;
    fpPkg::alignedMantissa s1MantissaA, s1MantissaB;
    logic s1SignA, s1SignB;
    logic s1ABigger, s1BBigger;
    fpPkg::sumMantissa sum, s2Sum;
    logic sumSign, s2SumSign;
    fpPkg::fpExponent s2Exponent;
    logic s2Sticky, s2ShiftOverflow;
    fpPkg::fpWord roundedWord;
    fpPkg::fpFlags roundFlags;

    fpClassify i_classify
    (
        .opA(opA), .opB(opB), .subtract(subtract),
        .signA(signA), .signB(signB),
        .exponentA(exponentA), .exponentB(exponentB),
        .mantissaA(mantissaA), .mantissaB(mantissaB),
        .nanA(nanA), .nanB(nanB), .infA(infA), .infB(infB),
        .zeroA(zeroA), .zeroB(zeroB), .subA(subA), .subB(subB)
    );

    alignment i_alignment
    (
        .exponentA(exponentA), .exponentB(exponentB),
        .mantissaA(mantissaA), .mantissaB(mantissaB),
        .subA(subA), .subB(subB), .nanA(nanA), .nanB(nanB),
        .infA(infA), .infB(infB), .zeroA(zeroA), .zeroB(zeroB),
        .signA(signA), .signB(signB),
        .exponentOut(exponentOut),
        .alignedMantissaA(alignedMantissaA), .alignedMantissaB(alignedMantissaB),
        .aBigger(aBigger), .bBigger(bBigger),
        .sticky(sticky), .shiftOverflow(shiftOverflow), .bypass(bypass)
    );

    mantissaAdder i_mantissaAdder
    (
        .alignedMantissaA(s1MantissaA), .alignedMantissaB(s1MantissaB),
        .signA(s1SignA), .signB(s1SignB),
        .aBigger(s1ABigger), .bBigger(s1BBigger),
        .sum(sum), .sumSign(sumSign)
    );

    normalizeRound i_normalizeRound
    (
        .sum(s2Sum), .sumSign(s2SumSign), .exponentIn(s2Exponent),
        .sticky(s2Sticky), .shiftOverflow(s2ShiftOverflow),
        .roundedWord(roundedWord), .roundFlags(roundFlags)
    );

    fpAdderControl i_control
    (
        .clk(clk), .reset(reset), .inValid(inValid),
        .exponentOut(exponentOut),
        .alignedMantissaA(alignedMantissaA), .alignedMantissaB(alignedMantissaB),
        .aBigger(aBigger), .bBigger(bBigger),
        .sticky(sticky), .shiftOverflow(shiftOverflow), .bypass(bypass),
        .signA(signA), .signB(signB), .nanA(nanA), .nanB(nanB),
        .infA(infA), .infB(infB), .zeroA(zeroA), .zeroB(zeroB),
        .opA(opA), .opB(opB),
        .sum(sum), .sumSign(sumSign),
        .roundedWord(roundedWord), .roundFlags(roundFlags),
        .s1MantissaA(s1MantissaA), .s1MantissaB(s1MantissaB),
        .s1SignA(s1SignA), .s1SignB(s1SignB),
        .s1ABigger(s1ABigger), .s1BBigger(s1BBigger),
        .s2Sum(s2Sum), .s2SumSign(s2SumSign), .s2Exponent(s2Exponent),
        .s2Sticky(s2Sticky), .s2ShiftOverflow(s2ShiftOverflow),
        .result(result), .flags(flags), .outValid(outValid)
    );

endmodule

`default_nettype wire

// ==== rtl/fpAdderControl.sv ====
// Adder pipeline registers and result select
`timescale 1ns/1ps
`default_nettype none

module fpAdderControl
(
    input wire clk,
    input wire reset,
    input wire inValid,
    input wire fpPkg::fpExponent exponentOut,
    input wire fpPkg::alignedMantissa alignedMantissaA,
    input wire fpPkg::alignedMantissa alignedMantissaB,
    input wire aBigger,
    input wire bBigger,
    input wire sticky,
    input wire shiftOverflow,
    input wire bypass,
    input wire signA,
    input wire signB,
    input wire nanA,
    input wire nanB,
    input wire infA,
    input wire infB,
    input wire zeroA,
    input wire zeroB,
    input wire fpPkg::fpWord opA,
    input wire fpPkg::fpWord opB,
    input wire fpPkg::sumMantissa sum,
    input wire sumSign,
    input wire fpPkg::fpWord roundedWord,
    input wire fpPkg::fpFlags roundFlags,
    output fpPkg::alignedMantissa s1MantissaA,
    output fpPkg::alignedMantissa s1MantissaB,
    output logic s1SignA,
    output logic s1SignB,
    output logic s1ABigger,
    output logic s1BBigger,
    output fpPkg::sumMantissa s2Sum,
    output logic s2SumSign,
    output fpPkg::fpExponent s2Exponent,
    output logic s2Sticky,
    output logic s2ShiftOverflow,
    output fpPkg::fpWord result,
    output fpPkg::fpFlags flags,
    output logic outValid
);

    logic s1Valid;
    logic s2Valid;
    fpPkg::fpExponent s1Exponent;
    logic s1Sticky;
    logic s1ShiftOverflow;
    logic s1Bypass;
    logic s1Nan;
    logic s1InfA, s1InfB;
    logic s1ZeroA, s1ZeroB;
    logic [30:0] s1MagA, s1MagB;
    fpPkg::fpWord tableWord;
    fpPkg::fpFlags tableFlags;
    logic s2Bypass;
    fpPkg::fpWord s2BypassWord;
    fpPkg::fpFlags s2BypassFlags;

    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            s1Valid <= 1'b0;
            s2Valid <= 1'b0;
            outValid <= 1'b0;
        end
        else
        begin
            s1Valid <= inValid;
            s2Valid <= s1Valid;
            outValid <= s2Valid;
        end
    end

    always_ff @(posedge clk)
    begin
        s1MantissaA <= alignedMantissaA;
        s1MantissaB <= alignedMantissaB;
        s1Exponent <= exponentOut;
        s1SignA <= signA;
        s1SignB <= signB; // already flipped for subtract.
        s1ABigger <= aBigger;
        s1BBigger <= bBigger;
        s1Sticky <= sticky;
        s1ShiftOverflow <= shiftOverflow;
        s1Bypass <= bypass;
        s1Nan <= nanA | nanB;
        s1InfA <= infA;
        s1InfB <= infB;
        s1ZeroA <= zeroA;
        s1ZeroB <= zeroB;
        s1MagA <= opA[30:0];
        s1MagB <= opB[30:0];
    end

    // special-case results, in priority order.
    always_comb
    begin
        tableFlags = '0;
        if (s1Nan | (s1InfA & s1InfB & (s1SignA != s1SignB)))
        begin
            tableWord = fpPkg::quietNan;
            tableFlags.invalid = 1'b1;
        end
        else if (s1InfA)
            tableWord = {s1SignA, s1MagA};
        else if (s1InfB)
            tableWord = {s1SignB, s1MagB};
        else if (s1ZeroA & s1ZeroB)
            tableWord = {s1SignA & s1SignB, 31'd0}; // -0 only from -0 + -0.
        else if (s1ZeroA)
            tableWord = {s1SignB, s1MagB};
        else if (s1ZeroB)
            tableWord = {s1SignA, s1MagA};
        else if (s1MagA == s1MagB)
            tableWord = '0; // exact cancellation.
        else
        begin
            tableWord = s1ABigger ? {s1SignA, s1MagA} : {s1SignB, s1MagB};
            tableFlags.inexact = 1'b1; // smaller operand far below an ulp.
        end
    end

    always_ff @(posedge clk)
    begin
        s2Sum <= sum;
        s2SumSign <= sumSign;
        s2Exponent <= s1Exponent;
        s2Sticky <= s1Sticky;
        s2ShiftOverflow <= s1ShiftOverflow;
        s2Bypass <= s1Bypass;
        s2BypassWord <= tableWord;
        s2BypassFlags <= tableFlags;
    end

    always_ff @(posedge clk)
    begin
        result <= s2Bypass ? s2BypassWord : roundedWord;
        flags <= s2Bypass ? s2BypassFlags : roundFlags;
    end

endmodule

`default_nettype wire

// ==== fpAdder/normalizeRound.sv ====
// Normalize and round to nearest even
`timescale 1ns/1ps
`default_nettype none

module normalizeRound
(
    input wire fpPkg::sumMantissa sum,
    input wire sumSign,
    input wire fpPkg::fpExponent exponentIn,
    input wire sticky,
    input wire shiftOverflow,
    output fpPkg::fpWord roundedWord,
    output fpPkg::fpFlags roundFlags
);

    fpPkg::sumMantissa corrected;
    fpPkg::alignedMantissa normalized;
    fpPkg::fpExponent shiftLimit;
    logic [8:0] normExponent;
    logic [5:0] zeroCount;
    logic [5:0] shiftLeft;
    logic carryLost;
    logic guardBit;
    logic roundBit;
    logic stickyBit;
    logic roundUp;
    logic [30:0] magnitude;
    logic [30:0] roundedMagnitude;
    logic overflow;

    // borrow for the bits lost during alignment.
    assign corrected = sum - 33'(shiftOverflow);
    assign shiftLimit = exponentIn - 8'd1;

    always_comb
    begin
        zeroCount = 6'd32;
        for (int i = 0; i < 32; i++)
        begin
            if (corrected[i])
                zeroCount = 6'(31 - i);
        end
    end

    assign shiftLeft = (8'(zeroCount) > shiftLimit) ? shiftLimit[5:0] : zeroCount; // floor at exp 1.

    always_comb
    begin
        if (corrected[32])
        begin
            normalized = corrected[32:1];
            carryLost = corrected[0];
            normExponent = {1'b0, exponentIn} + 9'd1;
        end
        else
        begin
            normalized = corrected[31:0] << shiftLeft;
            carryLost = 1'b0;
            normExponent = {1'b0, exponentIn} - 9'(shiftLeft);
        end
    end

    assign guardBit = normalized[7];
    assign roundBit = normalized[6];
    assign stickyBit = (|normalized[5:0]) | carryLost | sticky | shiftOverflow;
    assign roundUp = guardBit & (roundBit | stickyBit | normalized[8]); // ties to even.

    // a clear hidden bit means a subnormal result.
    assign magnitude = {normalized[31] ? normExponent[7:0] : 8'd0, normalized[30:8]};
    assign roundedMagnitude = magnitude + 31'(roundUp); // carry runs into the exponent.

    assign overflow = (normExponent >= 9'(fpPkg::exponentMax))
                    | (roundedMagnitude[30:23] == fpPkg::exponentMax);

    always_comb
    begin
        if (overflow)
            roundedWord = {sumSign, fpPkg::exponentMax, 23'd0};
        else
            roundedWord = {sumSign, roundedMagnitude};
        roundFlags.invalid = 1'b0;
        roundFlags.overflow = overflow;
        roundFlags.inexact = guardBit | roundBit | stickyBit | overflow;
    end

endmodule

`default_nettype wire

// ==== fpAdder/mantissaAdder.sv ====
// Signed magnitude mantissa adder
`timescale 1ns/1ps
`default_nettype none

module mantissaAdder
(
    input wire fpPkg::alignedMantissa alignedMantissaA,
    input wire fpPkg::alignedMantissa alignedMantissaB,
    input wire signA,
    input wire signB,
    input wire aBigger,
    input wire bBigger,
    output fpPkg::sumMantissa sum,
    output logic sumSign
);

    logic aLarger;

    // exponents decide, mantissas break a tie.
    assign aLarger = aBigger | (~bBigger & (alignedMantissaA >= alignedMantissaB));

    always_comb
    begin
        if (signA == signB)
        begin
            sum = {1'b0, alignedMantissaA} + {1'b0, alignedMantissaB};
            sumSign = signA;
        end
        else if (aLarger)
        begin
            sum = {1'b0, alignedMantissaA} - {1'b0, alignedMantissaB};
            sumSign = signA;
        end
        else
        begin
            sum = {1'b0, alignedMantissaB} - {1'b0, alignedMantissaA};
            sumSign = signB;
        end
    end

endmodule

`default_nettype wire

// ==== fpAdder/alignment.sv ====
// Exponent compare and mantissa alignment
`timescale 1ns/1ps
`default_nettype none

module alignment
(
    input wire fpPkg::fpExponent exponentA,
    input wire fpPkg::fpExponent exponentB,
    input wire fpPkg::fpMantissa mantissaA,
    input wire fpPkg::fpMantissa mantissaB,
    input wire subA,
    input wire subB,
    input wire nanA,
    input wire nanB,
    input wire infA,
    input wire infB,
    input wire zeroA,
    input wire zeroB,
    input wire signA,
    input wire signB,
    output fpPkg::fpExponent exponentOut,
    output fpPkg::alignedMantissa alignedMantissaA,
    output fpPkg::alignedMantissa alignedMantissaB,
    output logic aBigger,
    output logic bBigger,
    output logic sticky,
    output logic shiftOverflow,
    output logic bypass
);

    fpPkg::fpExponent effectiveA;
    fpPkg::fpExponent effectiveB;
    fpPkg::fpExponent shiftAmount;
    fpPkg::alignedMantissa fullA;
    fpPkg::alignedMantissa fullB;
    fpPkg::alignedMantissa lostBits;
    logic cancel;

    assign effectiveA = subA ? 8'd1 : exponentA; // subnormals sit at exponent 1.
    assign effectiveB = subB ? 8'd1 : exponentB;
    assign fullA = {~subA, mantissaA, {fpPkg::guardWidth{1'b0}}};
    assign fullB = {~subB, mantissaB, {fpPkg::guardWidth{1'b0}}};

    assign aBigger = exponentA > exponentB;
    assign bBigger = exponentA < exponentB;

    always_comb
    begin
        if (bBigger)
        begin
            exponentOut = effectiveB;
            shiftAmount = effectiveB - effectiveA;
            alignedMantissaA = fullA >> shiftAmount;
            alignedMantissaB = fullB;
            lostBits = fullA & ~({$bits(fpPkg::alignedMantissa){1'b1}} << shiftAmount);
        end
        else
        begin
            exponentOut = effectiveA;
            shiftAmount = effectiveA - effectiveB;
            alignedMantissaA = fullA;
            alignedMantissaB = fullB >> shiftAmount;
            lostBits = fullB & ~({$bits(fpPkg::alignedMantissa){1'b1}} << shiftAmount);
        end
    end

    assign cancel = (exponentA == exponentB) & (mantissaA == mantissaB) & (signA != signB);

    assign sticky = |lostBits;
    assign shiftOverflow = sticky & (signA != signB); // window difference is one too big.

    assign bypass = nanA | nanB | infA | infB | zeroA | zeroB | cancel
                  | (shiftAmount >= fpPkg::bypassShift);

endmodule

`default_nettype wire

// ==== rtl/fpClassify.sv ====
// Operand field split and class decode
`timescale 1ns/1ps
`default_nettype none

module fpClassify
(
    input wire fpPkg::fpWord opA,
    input wire fpPkg::fpWord opB,
    input wire subtract,
    output logic signA,
    output logic signB,
    output fpPkg::fpExponent exponentA,
    output fpPkg::fpExponent exponentB,
    output fpPkg::fpMantissa mantissaA,
    output fpPkg::fpMantissa mantissaB,
    output logic nanA,
    output logic nanB,
    output logic infA,
    output logic infB,
    output logic zeroA,
    output logic zeroB,
    output logic subA,
    output logic subB
);

    assign signA = opA[31];
    assign signB = opB[31] ^ subtract; // a - b is a + (-b).

    assign exponentA = opA[30:23];
    assign exponentB = opB[30:23];
    assign mantissaA = opA[22:0];
    assign mantissaB = opB[22:0];

    assign nanA = (exponentA == fpPkg::exponentMax) & (mantissaA != '0);
    assign nanB = (exponentB == fpPkg::exponentMax) & (mantissaB != '0);
    assign infA = (exponentA == fpPkg::exponentMax) & (mantissaA == '0);
    assign infB = (exponentB == fpPkg::exponentMax) & (mantissaB == '0);

    assign zeroA = (exponentA == '0) & (mantissaA == '0);
    assign zeroB = (exponentB == '0) & (mantissaB == '0);
    assign subA = (exponentA == '0) & (mantissaA != '0);
    assign subB = (exponentB == '0) & (mantissaB != '0);

endmodule

`default_nettype wire

// ==== common/fpPkg.sv ====
// Single-precision float definitions
`default_nettype none

package fpPkg;

    localparam int exponentWidth = 8;
    localparam int fractionWidth = 23;
    localparam int guardWidth = 8;
    localparam int wordWidth = 1 + exponentWidth + fractionWidth;

    typedef logic [wordWidth-1:0] fpWord;
    typedef logic [exponentWidth-1:0] fpExponent;
    typedef logic [fractionWidth-1:0] fpMantissa;

    // hidden bit, fraction, guard bits.
    typedef logic [fractionWidth+guardWidth:0] alignedMantissa;
    typedef logic [fractionWidth+guardWidth+1:0] sumMantissa; // plus carry.

    typedef struct packed {
        logic invalid;
        logic overflow;
        logic inexact;
    } fpFlags;

    localparam fpWord quietNan = 32'h7FC00000;
    localparam fpExponent exponentMax = 8'd255;
    localparam int bypassShift = 32;

endpackage

`default_nettype wire
